//--- verilog/adxl362_defines.svh
`ifndef ADXL362_DEFINES_SVH
`define ADXL362_DEFINES_SVH

// SPI command bytes
`define ADXL362_CMD_WRITE 8'h0A
`define ADXL362_CMD_READ 8'h0B
`define ADXL362_CMD_FIFO 8'h0D

// Identification register addresses
`define ADXL362_ADDR_DEVID_AD 6'h00
`define ADXL362_ADDR_DEVID_MST 6'h01
`define ADXL362_ADDR_PARTID 6'h02
`define ADXL362_ADDR_REVID 6'h03

// Fixed identification contents
`define ADXL362_DEVID_AD 8'hAD
`define ADXL362_DEVID_MST 8'h1D
`define ADXL362_PARTID 8'hF2
`define ADXL362_REVID 8'h01

// Soft reset register, also the first writable address
`define ADXL362_ADDR_SOFT_RESET 6'h1F
`define ADXL362_SOFT_RESET_KEY 8'h52

// Top of the writable configuration block
`define ADXL362_ADDR_CFG_LAST 6'h2E

`endif

//--- verilog/adxl362_spi_pkg.sv
`default_nettype none

`include "adxl362_defines.svh"

package adxl362_spi_pkg;

   typedef logic [7:0] spi_byte_t;

   typedef enum logic [1:0] {
      cmd_write,
      cmd_read,
      cmd_fifo,
      cmd_unknown
   } spi_cmd_t;

   // Transaction progress in the clk_16mhz domain
   typedef enum logic [2:0] {
      state_idle,
      state_command,
      state_address,
      state_write_data,
      state_read_data,
      state_fifo_data,
      state_ignore
   } spi_state_t;

   function automatic spi_cmd_t decode_cmd(input spi_byte_t cmd_byte);
      spi_cmd_t cmd;
      case (cmd_byte)
         `ADXL362_CMD_WRITE: cmd = cmd_write;
         `ADXL362_CMD_READ:  cmd = cmd_read;
         `ADXL362_CMD_FIFO:  cmd = cmd_fifo;
         default:            cmd = cmd_unknown;
      endcase
      return cmd;
   endfunction

endpackage

`default_nettype wire

//--- verilog/adxl362_reg_pkg.sv
`default_nettype none

package adxl362_reg_pkg;

   // Six bits cover the whole map up to 0x2E
   typedef logic [5:0] reg_addr_t;

   typedef logic [7:0] reg_data_t;

endpackage

`default_nettype wire

//--- verilog/adxl362_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module adxl362_fifo (
   input  wire                             wire_clk,
   input  wire                             clk_16mhz,
   input  wire                             nCS,
   input  wire                             write,
   input  wire adxl362_spi_pkg::spi_byte_t data_wr,
   input  wire                             read,
   output adxl362_spi_pkg::spi_byte_t      data_rd,
   output logic                            fifo_empty
);

   import adxl362_spi_pkg::*;

   spi_byte_t  mem [0:3];

   // Pointers carry one extra bit to tell full from empty
   logic [2:0] wr_ptr;
   logic [2:0] wr_ptr_next;
   logic [2:0] wr_gray;
   logic [2:0] wr_gray_meta;
   logic [2:0] wr_gray_sync;
   logic [2:0] rd_ptr;
   logic [2:0] rd_gray;

   assign wr_ptr_next = wr_ptr + 3'd1;

   // Write side runs on sclk
   always_ff @(posedge wire_clk or posedge nCS) begin
      if (nCS) begin
         wr_ptr  <= 3'd0;
         wr_gray <= 3'd0;
      end else if (write) begin
         wr_ptr  <= wr_ptr_next;
         wr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
      end
   end

   always_ff @(posedge wire_clk) begin
      if (write) begin
         mem[wr_ptr[1:0]] <= data_wr;
      end
   end

   // Two-flop synchronizer of the Gray write pointer
   always_ff @(posedge clk_16mhz or posedge nCS) begin
      if (nCS) begin
         wr_gray_meta <= 3'd0;
         wr_gray_sync <= 3'd0;
      end else begin
         wr_gray_meta <= wr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   always_ff @(posedge clk_16mhz or posedge nCS) begin
      if (nCS) begin
         rd_ptr <= 3'd0;
      end else if (read) begin
         rd_ptr <= rd_ptr + 3'd1;
      end
   end

   assign rd_gray    = rd_ptr ^ (rd_ptr >> 1);
   assign fifo_empty = (wr_gray_sync == rd_gray);
   assign data_rd    = mem[rd_ptr[1:0]];

   // Reader must respect the synchronized empty flag
   a_no_read_empty: assert property (
      @(posedge clk_16mhz) disable iff (nCS) read |-> !fifo_empty);

   // The master has no back-pressure, so overflow means it clocked too fast
   a_no_write_full: assert property (
      @(posedge wire_clk) disable iff (nCS) write |-> ((wr_ptr - rd_ptr) != 3'd4));

endmodule

`default_nettype wire

//--- verilog/adxl362_spi.sv
`timescale 1ns/1ps
`default_nettype none

module adxl362_spi (
   input  wire                             clk_16mhz,
   input  wire                             nCS,
   input  wire                             sclk,
   input  wire                             mosi,
   output logic                            miso,
   output adxl362_reg_pkg::reg_addr_t      address,
   output adxl362_reg_pkg::reg_data_t      write_data,
   output logic                            write,
   input  wire adxl362_reg_pkg::reg_data_t read_data
);

   import adxl362_spi_pkg::*;
   import adxl362_reg_pkg::*;

   // SCLK domain
   logic [2:0] bit_count;
   logic [6:0] rx_shift;
   spi_byte_t  rx_byte;
   logic       byte_done;
   logic       between;
   logic       miso_bit;

   // clk_16mhz domain
   spi_state_t state;
   spi_cmd_t   cmd;
   reg_data_t  tx_data;
   spi_byte_t  fifo_byte;
   logic       fifo_empty;
   logic       pop;
   logic       load;

   always_ff @(posedge sclk or posedge nCS) begin
      if (nCS) begin
         bit_count <= 3'd0;
      end else begin
         bit_count <= bit_count + 3'd1;
      end
   end

   always_ff @(posedge sclk) begin
      rx_shift <= {rx_shift[5:0], mosi};
   end

   // Eighth rising edge completes the byte, pushed on that same edge
   assign byte_done = (bit_count == 3'd7);
   assign rx_byte   = {rx_shift, mosi};

   adxl362_fifo rx_fifo (
      .wire_clk   (sclk),
      .clk_16mhz  (clk_16mhz),
      .nCS        (nCS),
      .write      (byte_done),
      .data_wr    (rx_byte),
      .read       (pop),
      .data_rd    (fifo_byte),
      .fifo_empty (fifo_empty)
   );

   // Transmit side, bits 6 to 0 change on falling edges
   always_ff @(negedge sclk or posedge nCS) begin
      if (nCS) begin
         between  <= 1'b1;
         miso_bit <= 1'b0;
      end else begin
         between  <= (bit_count == 3'd0);
         miso_bit <= tx_data[3'd7 - bit_count];
      end
   end

   // Between bytes the MSB follows tx_data so a late load still makes it
   assign miso = between ? tx_data[7] : miso_bit;

   always_comb begin
      case (state)
         state_command,
         state_address,
         state_fifo_data,
         state_ignore:     pop = !fifo_empty;
         state_write_data: pop = !fifo_empty && !write;
         state_read_data:  pop = !fifo_empty && !load;
         default:          pop = 1'b0;
      endcase
   end

   always_ff @(posedge clk_16mhz or posedge nCS) begin
      if (nCS) begin
         state   <= state_idle;
         cmd     <= cmd_unknown;
         address <= '0;
         write   <= 1'b0;
         load    <= 1'b0;
         tx_data <= '0;
      end else begin
         write <= 1'b0;
         case (state)
            state_idle: begin
               if (!fifo_empty) begin
                  state <= state_command;
               end
            end
            state_command: begin
               if (pop) begin
                  cmd <= decode_cmd(fifo_byte);
                  if (decode_cmd(fifo_byte) == cmd_unknown) begin
                     state <= state_ignore;
                  end else begin
                     state <= state_address;
                  end
               end
            end
            state_address: begin
               if (pop) begin
                  address <= fifo_byte[5:0];
                  case (cmd)
                     cmd_write: state <= state_write_data;
                     cmd_read: begin
                        state <= state_read_data;
                        load  <= 1'b1;
                     end
                     cmd_fifo: begin
                        state   <= state_fifo_data;
                        tx_data <= '0;
                     end
                     default: state <= state_ignore;
                  endcase
               end
            end
            state_write_data: begin
               // Step to the next address the cycle after the pulse
               if (write) begin
                  address <= address + 6'd1;
               end else if (pop) begin
                  write <= 1'b1;
               end
            end
            state_read_data: begin
               if (load) begin
                  tx_data <= read_data;
                  address <= address + 6'd1;
                  load    <= 1'b0;
               end else if (pop) begin
                  load <= 1'b1;
               end
            end
            // Sample FIFO is not modelled, dummy bytes are drained
            state_fifo_data: state <= state_fifo_data;
            state_ignore:    state <= state_ignore;
            default:         state <= state_ignore;
         endcase
      end
   end

   always_ff @(posedge clk_16mhz) begin
      if (state == state_write_data && pop) begin
         write_data <= fifo_byte;
      end
   end

   // Register file sees exactly one edge per data byte
   a_write_single: assert property (
      @(posedge clk_16mhz) disable iff (nCS) write |=> !write);

   a_write_idle: assert property (
      @(posedge clk_16mhz) nCS |-> !write);

endmodule

`default_nettype wire

//--- verilog/adxl362_registers.sv
`timescale 1ns/1ps
`default_nettype none

`include "adxl362_defines.svh"

module adxl362_registers (
   input  wire                             clk_16mhz,
   input  wire adxl362_reg_pkg::reg_addr_t address,
   input  wire adxl362_reg_pkg::reg_data_t write_data,
   input  wire                             write,
   output adxl362_reg_pkg::reg_data_t      read_data
);

   import adxl362_reg_pkg::*;

   localparam int cfg_count = `ADXL362_ADDR_CFG_LAST - `ADXL362_ADDR_SOFT_RESET + 1;

   // Configuration block 0x1F to 0x2E, outlives chip select
   reg_data_t cfg_mem [0:cfg_count-1] = '{default: '0};
   reg_addr_t cfg_offset;
   logic      cfg_hit;
   logic      soft_reset;

   assign cfg_offset = address - `ADXL362_ADDR_SOFT_RESET;
   assign cfg_hit    = (address >= `ADXL362_ADDR_SOFT_RESET) &&
                       (address <= `ADXL362_ADDR_CFG_LAST);

   // Key written to 0x1F
   assign soft_reset = (address == `ADXL362_ADDR_SOFT_RESET) &&
                       (write_data == `ADXL362_SOFT_RESET_KEY);

   always_ff @(posedge clk_16mhz) begin
      if (write && cfg_hit) begin
         if (soft_reset) begin
            for (int i = 0; i < cfg_count; i++) begin
               cfg_mem[i] <= '0;
            end
         end else begin
            cfg_mem[cfg_offset[3:0]] <= write_data;
         end
      end
   end

   always_comb begin
      case (address)
         `ADXL362_ADDR_DEVID_AD:  read_data = `ADXL362_DEVID_AD;
         `ADXL362_ADDR_DEVID_MST: read_data = `ADXL362_DEVID_MST;
         `ADXL362_ADDR_PARTID:    read_data = `ADXL362_PARTID;
         `ADXL362_ADDR_REVID:     read_data = `ADXL362_REVID;
         default: begin
            // Unmapped space reads as zero
            read_data = cfg_hit ? cfg_mem[cfg_offset[3:0]] : '0;
         end
      endcase
   end

   // Transmit register in the SPI slave latches this every read byte
   a_read_known: assert property (
      @(posedge clk_16mhz) !$isunknown(read_data));

endmodule

`default_nettype wire

//--- verilog/adxl362.sv
`timescale 1ns/1ps
`default_nettype none

module adxl362 (
   input  wire clk_16mhz,
   input  wire nCS,
   input  wire sclk,
   input  wire mosi,
   output wire miso
);

   import adxl362_reg_pkg::*;

   reg_addr_t address;
   reg_data_t write_data;
   reg_data_t read_data;
   wire       write;

   adxl362_spi spi0 (
      .clk_16mhz  (clk_16mhz),
      .nCS        (nCS),
      .sclk       (sclk),
      .mosi       (mosi),
      .miso       (miso),
      .address    (address),
      .write_data (write_data),
      .write      (write),
      .read_data  (read_data)
   );

   adxl362_registers registers0 (
      .clk_16mhz  (clk_16mhz),
      .address    (address),
      .write_data (write_data),
      .write      (write),
      .read_data  (read_data)
   );

endmodule

`default_nettype wire

//--- bench/adxl362_clock.sv
`timescale 1ns/1ps
`default_nettype none

module adxl362_clock (
   output logic clk_16mhz
);

   // 100 ns period, slower than the real part
   localparam int half_period = 50;

   initial begin
      clk_16mhz = 1'b0;
   end

   always begin
      #(half_period) clk_16mhz = ~clk_16mhz;
   end

endmodule

`default_nettype wire

//--- bench/adxl362_tb.sv
`timescale 1ns/1ps
`default_nettype none

module adxl362_tb;

   localparam int max_bytes    = 8;
   localparam int half_cycles  = 4;
   localparam int gap_cycles   = 10;
   localparam int settle_limit = 8;
   localparam int line_limit   = 200;

   logic clk_16mhz;
   logic nCS;
   logic sclk;
   logic mosi;
   wire  miso;

   int error_count;
   int check_count;
   int case_count;

   // Fields of the current case line
   logic [127:0] test_name;
   logic [7:0]   cmd_byte;
   logic [7:0]   addr_byte;
   int           byte_count;
   int           last_bits;
   logic [15:0]  send_tok [max_bytes];
   logic [15:0]  expect_tok [max_bytes];

   adxl362_clock clock0 (
      .clk_16mhz (clk_16mhz)
   );

   adxl362 dut0 (
      .clk_16mhz (clk_16mhz),
      .nCS       (nCS),
      .sclk      (sclk),
      .mosi      (mosi),
      .miso      (miso)
   );

   function automatic logic [3:0] hex_value(input logic [7:0] c);
      logic [3:0] v;
      if (c >= "0" && c <= "9") begin
         v = 4'(c - "0");
      end else if (c >= "A" && c <= "F") begin
         v = 4'(c - "A" + 8'd10);
      end else if (c >= "a" && c <= "f") begin
         v = 4'(c - "a" + 8'd10);
      end else begin
         v = 4'h0;
      end
      return v;
   endfunction

   // Bit 8 set when the token holds a byte, clear for "--"
   function automatic logic [8:0] token_byte(input logic [15:0] tok);
      logic [8:0] result;
      if (tok == "--") begin
         result = 9'h000;
      end else begin
         result = {1'b1, hex_value(tok[15:8]), hex_value(tok[7:0])};
      end
      return result;
   endfunction

   // Returns 10 ns after the n-th rising edge
   task automatic after_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge clk_16mhz);
      end
      #10;
   endtask

   // Mode 0, MSB first, miso sampled just before each rising edge
   task automatic shift_byte(input logic [7:0] value, input int bits,
                             output logic [7:0] captured);
      captured = 8'h00;
      for (int i = 7; i >= 8 - bits; i--) begin
         mosi = value[i];
         after_cycles(half_cycles);
         captured[i] = miso;
         sclk = 1'b1;
         after_cycles(half_cycles);
         sclk = 1'b0;
      end
   endtask

   task automatic wait_miso_low();
      int waited;
      waited = 0;
      while (miso !== 1'b0 && waited < settle_limit) begin
         after_cycles(1);
         waited++;
      end
      if (miso !== 1'b0) begin
         $display("Error in %0s: miso still %b %0d cycles after nCS rose",
                  test_name, miso, waited);
         error_count++;
      end
   endtask

   task automatic run_case();
      logic [8:0] sent;
      logic [8:0] expected;
      logic [7:0] captured;
      int         bits;
      nCS = 1'b0;
      after_cycles(half_cycles);
      shift_byte(cmd_byte, 8, captured);
      after_cycles(gap_cycles);
      shift_byte(addr_byte, 8, captured);
      for (int k = 0; k < byte_count; k++) begin
         after_cycles(gap_cycles);
         sent     = token_byte(send_tok[k]);
         expected = token_byte(expect_tok[k]);
         bits     = (k == byte_count - 1) ? last_bits : 8;
         shift_byte(sent[7:0], bits, captured);
         if (expected[8]) begin
            check_count++;
            if (captured !== expected[7:0]) begin
               $display("Fail %0s byte %0d: expected %02h, actual %02h",
                        test_name, k, expected[7:0], captured);
               error_count++;
            end
         end
      end
      // Short byte means nCS rises mid-byte
      if (last_bits < 8) begin
         after_cycles(2);
      end else begin
         after_cycles(gap_cycles);
      end
      nCS = 1'b1;
      after_cycles(1);
      wait_miso_low();
      after_cycles(gap_cycles);
   endtask

   initial begin
      int    fd;
      int    fields;
      int    status;
      int    line_count;
      string line;
      nCS         = 1'b1;
      sclk        = 1'b0;
      mosi        = 1'b0;
      error_count = 0;
      check_count = 0;
      case_count  = 0;
      test_name   = "reset";
      after_cycles(5);
      wait_miso_low();
      fd = $fopen("bench/adxl362_cases.txt", "r");
      if (fd == 0) begin
         $display("Error: cannot open bench/adxl362_cases.txt");
         error_count++;
      end else begin
         line_count = 0;
         while (!$feof(fd) && line_count < line_limit) begin
            line   = "";
            status = $fgets(line, fd);
            line_count++;
            if (status > 0 && line.len() > 1 && line.getc(0) != "#") begin
               fields = $sscanf(line,
                  "%s %h %h %d %d %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s %s",
                  test_name, cmd_byte, addr_byte, byte_count, last_bits,
                  send_tok[0], send_tok[1], send_tok[2], send_tok[3],
                  send_tok[4], send_tok[5], send_tok[6], send_tok[7],
                  expect_tok[0], expect_tok[1], expect_tok[2], expect_tok[3],
                  expect_tok[4], expect_tok[5], expect_tok[6], expect_tok[7]);
               if (fields != 21 || byte_count > max_bytes) begin
                  $display("Error: case line %0d is malformed", line_count);
                  error_count++;
               end else begin
                  case_count++;
                  run_case();
               end
            end
         end
         $fclose(fd);
      end
      if (case_count == 0) begin
         $display("Error: no cases were run");
         error_count++;
      end
      $display("%0d cases, %0d checks, %0d errors", case_count, check_count, error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/adxl362_cases.txt
# name cmd addr count bits, then 8 bytes sent on mosi and 8 bytes expected on miso
# bits is the length of the last data byte, -- marks an unused or unchecked byte
id_burst     0B 00 4 8  00 00 00 00 -- -- -- --  AD 1D F2 01 -- -- -- --
wr_single    0A 20 1 8  5A -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
rd_single    0B 20 1 8  00 -- -- -- -- -- -- --  5A -- -- -- -- -- -- --
wr_burst     0A 24 4 8  11 22 33 44 -- -- -- --  -- -- -- -- -- -- -- --
rd_burst     0B 24 4 8  00 00 00 00 -- -- -- --  11 22 33 44 -- -- -- --
wr_top       0A 2E 1 8  C3 -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
rd_wrap      0B 2D 3 8  00 00 00 -- -- -- -- --  00 C3 00 -- -- -- -- --
wr_readonly  0A 00 1 8  77 -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
wr_unmapped  0A 10 1 8  66 -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
rd_readonly  0B 00 1 8  00 -- -- -- -- -- -- --  AD -- -- -- -- -- -- --
rd_unmapped  0B 10 1 8  00 -- -- -- -- -- -- --  00 -- -- -- -- -- -- --
bad_cmd      55 20 2 8  99 98 -- -- -- -- -- --  -- -- -- -- -- -- -- --
rd_after_bad 0B 20 2 8  00 00 -- -- -- -- -- --  5A 00 -- -- -- -- -- --
wr_fill      0A 21 3 8  A1 A2 A3 -- -- -- -- --  -- -- -- -- -- -- -- --
soft_pre     0B 20 8 8  00 00 00 00 00 00 00 00  5A A1 A2 A3 11 22 33 44
soft_reset   0A 1F 1 8  52 -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
soft_check   0B 20 8 8  00 00 00 00 00 00 00 00  00 00 00 00 00 00 00 00
rd_key       0B 1F 1 8  00 -- -- -- -- -- -- --  00 -- -- -- -- -- -- --
fifo_read    0D 00 2 8  00 00 -- -- -- -- -- --  00 00 -- -- -- -- -- --
wr_restore   0A 20 1 8  3C -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
wr_abort     0A 20 1 4  C5 -- -- -- -- -- -- --  -- -- -- -- -- -- -- --
rd_abort     0B 20 1 8  00 -- -- -- -- -- -- --  3C -- -- -- -- -- -- --

//--- filelist.f
+incdir+verilog
verilog/adxl362_spi_pkg.sv
verilog/adxl362_reg_pkg.sv
verilog/adxl362_fifo.sv
verilog/adxl362_spi.sv
verilog/adxl362_registers.sv
verilog/adxl362.sv
bench/adxl362_clock.sv
bench/adxl362_tb.sv

//--- Makefile
# Verilator simulation of the ADXL362 SPI model

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module adxl362_tb -Mdir obj_dir -o adxl362_sim
	-./obj_dir/adxl362_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "FAIL: run did not finish"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
